// File: uart_rx_pkg.sv
////////////////////////////////////////////////////////////
// Shared constants and FSM type for the 8-bit UART receiver
// x8 oversampling is assumed throughout, so OVS must stay a power of two
// Parity mode is {even, enable}, so bit 0 alone turns parity on
////////////////////////////////////////////////////////////
package uart_rx_pkg;

   // Frame geometry
   localparam int DATA_W    = 8;             // Data bits per frame
   localparam int BIT_IDX_W = 3;             // Index into the data bits

   // Oversampling
   localparam int OVS     = 8;               // Samples per bit
   localparam int PHASE_W = $clog2(OVS);     // Bit-phase counter width

   // Sample points inside one bit, typed to the counter width
   localparam logic [PHASE_W-1:0] MID_PHASE  = PHASE_W'(OVS / 2 - 1);
   localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(OVS - 1);

   // Bit positions inside i_parity_mode
   localparam int PAR_EN_BIT   = 0;          // 1 = parity bit present
   localparam int PAR_EVEN_BIT = 1;          // 1 = even, 0 = odd

   // Receiver states, one-hot
   typedef enum logic [5:0] {
      IDLE   = 6'b00_0001,                   // Hunting or inside start bit
      DATA   = 6'b00_0010,                   // Eight data bits
      PARITY = 6'b00_0100,                   // Optional parity bit
      STOP_P = 6'b00_1000,                   // First of two stop bits
      STOP_F = 6'b01_0000,                   // Final stop bit
      BUFF   = 6'b10_0000                    // One clock, hands frame to output
   } rx_state_t;

endpackage

// File: uart_rx_sampler.sv
////////////////////////////////////////////////////////////
// Start-edge hunt and x8 bit-phase counter
// i_baud_clk must be a one-clock strobe, at most one per four clocks
// Edge is seen between two ticks only, so glitches between ticks are missed
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx_sampler (
   input  logic clk,
   input  logic rstn,
   input  logic i_baud_clk,     // x8 bit-rate strobe
   input  logic i_rx,           // Serial line, idle high
   input  logic i_hunt,         // Controller sits in IDLE
   input  logic i_frame_done,   // Final stop sampled
   output logic o_sync,
   output logic o_mid_tick,
   output logic o_last_tick,
   output logic o_rx_ready
);

   logic                             rx_prev;      // Line as of previous tick
   logic                             sync_q;       // Locked onto a frame
   logic [uart_rx_pkg::PHASE_W-1:0]  phase_q;      // Shared bit phase
   logic                             hunting;
   logic                             start_edge;
   logic                             mid_tick;
   logic                             last_tick;
   logic                             false_start;

   // Only look for an edge when idle and not yet locked
   assign hunting    = i_hunt & ~sync_q;
   assign start_edge = i_baud_clk & hunting & rx_prev & ~i_rx;   // High to low

   assign mid_tick  = i_baud_clk & sync_q & (phase_q == uart_rx_pkg::MID_PHASE);
   assign last_tick = i_baud_clk & sync_q & (phase_q == uart_rx_pkg::LAST_PHASE);

   // Start bit back high at its middle, so a glitch
   assign false_start = mid_tick & i_hunt & i_rx;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         rx_prev <= 1'b0;               // A line low out of reset is no edge
      end else if (i_baud_clk && hunting) begin
         rx_prev <= i_rx;
      end
   end

   // Sync flag
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         sync_q <= 1'b0;
      end else if (i_frame_done || false_start) begin
         sync_q <= 1'b0;                // Frame over or rejected
      end else if (start_edge) begin
         sync_q <= 1'b1;
      end
   end

   // Phase counter, wraps at OVS by its width
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         phase_q <= '0;
      end else if (i_frame_done || false_start) begin
         phase_q <= '0;
      end else if (start_edge || (i_baud_clk && sync_q)) begin
         phase_q <= phase_q + 1'b1;     // Edge tick counts as phase 0
      end
   end

   assign o_sync      = sync_q;
   assign o_mid_tick  = mid_tick;
   assign o_last_tick = last_tick;
   assign o_rx_ready  = ~sync_q;        // Free again from final stop middle

endmodule

// File: uart_rx_frame_ctrl.sv
////////////////////////////////////////////////////////////
// Frame FSM, start through stop, one-hot
// Parity and frame mode are read live and must hold during a frame
// Leaves STOP_F at the stop middle, so BUFF lasts one clock
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx_frame_ctrl (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                i_sync,
   input  logic                                i_mid_tick,
   input  logic                                i_last_tick,
   input  logic [1:0]                          i_parity_mode,
   input  logic                                i_frame_mode,    // 1 = two stop bits
   output logic                                o_hunt,
   output logic                                o_data_cap,
   output logic [uart_rx_pkg::BIT_IDX_W-1:0]   o_bit_idx,
   output logic                                o_par_cap,
   output logic                                o_stop1_cap,
   output logic                                o_stop2_cap,
   output logic                                o_frame_done,
   output logic                                o_buff
);

   uart_rx_pkg::rx_state_t                state_q;
   uart_rx_pkg::rx_state_t                state_nx;
   logic [uart_rx_pkg::BIT_IDX_W-1:0]     bit_cnt_q;     // Current data bit
   logic                                  last_data;
   logic                                  par_en;
   uart_rx_pkg::rx_state_t                stop_state;    // First stop state for mode

   assign par_en    = i_parity_mode[uart_rx_pkg::PAR_EN_BIT];
   assign last_data = (int'(bit_cnt_q) == uart_rx_pkg::DATA_W - 1);

   // Two stop bits start in STOP_P, one goes straight to STOP_F
   assign stop_state = i_frame_mode ? uart_rx_pkg::STOP_P : uart_rx_pkg::STOP_F;

   always_comb begin
      state_nx = state_q;
      case (state_q)
         uart_rx_pkg::IDLE: begin
            if (i_last_tick) begin       // Start bit already checked at middle
               state_nx = uart_rx_pkg::DATA;
            end
         end
         uart_rx_pkg::DATA: begin
            if (i_last_tick && last_data) begin
               state_nx = par_en ? uart_rx_pkg::PARITY : stop_state;
            end
         end
         uart_rx_pkg::PARITY: begin
            if (i_last_tick) begin
               state_nx = stop_state;
            end
         end
         uart_rx_pkg::STOP_P: begin
            if (i_last_tick) begin
               state_nx = uart_rx_pkg::STOP_F;
            end
         end
         uart_rx_pkg::STOP_F: begin
            // Done at the middle, second half of stop is free for hunting
            if (i_mid_tick) begin
               state_nx = uart_rx_pkg::BUFF;
            end
         end
         uart_rx_pkg::BUFF: begin
            state_nx = uart_rx_pkg::IDLE;  // Single clock
         end
         default: begin
            state_nx = uart_rx_pkg::IDLE;  // Lost one-hot, recover
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state_q <= uart_rx_pkg::IDLE;
      end else begin
         state_q <= state_nx;
      end
   end

   // Data bit counter
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bit_cnt_q <= '0;
      end else if (!i_sync) begin
         bit_cnt_q <= '0;                 // Between frames or after false start
      end else if (state_q == uart_rx_pkg::DATA && i_last_tick) begin
         bit_cnt_q <= bit_cnt_q + 1'b1;
      end
   end

   // Capture strobes, one per field middle
   assign o_data_cap   = (state_q == uart_rx_pkg::DATA)   & i_mid_tick;
   assign o_par_cap    = (state_q == uart_rx_pkg::PARITY) & i_mid_tick;
   assign o_stop1_cap  = (state_q == uart_rx_pkg::STOP_P) & i_mid_tick;
   assign o_stop2_cap  = (state_q == uart_rx_pkg::STOP_F) & i_mid_tick;
   assign o_frame_done = (state_q == uart_rx_pkg::STOP_F) & i_mid_tick;  // Drops sync

   assign o_bit_idx = bit_cnt_q;
   assign o_hunt    = (state_q == uart_rx_pkg::IDLE);
   assign o_buff    = (state_q == uart_rx_pkg::BUFF);

endmodule

// File: uart_rx_frame_check.sv
////////////////////////////////////////////////////////////
// Data, parity and stop captures with the error decisions
// Flags are combinational and only meaningful while BUFF is high
// Modes must match the ones used by the controller for the frame
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx_frame_check (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                i_rx,
   input  logic                                i_data_cap,
   input  logic [uart_rx_pkg::BIT_IDX_W-1:0]   i_bit_idx,
   input  logic                                i_par_cap,
   input  logic                                i_stop1_cap,
   input  logic                                i_stop2_cap,
   input  logic [1:0]                          i_parity_mode,
   input  logic                                i_frame_mode,
   output logic [uart_rx_pkg::DATA_W-1:0]      o_data,
   output logic                                o_parity_err,
   output logic                                o_frame_err,
   output logic                                o_break
);

   logic [uart_rx_pkg::DATA_W-1:0]  data_q;      // Assembled LSB first
   logic                            par_bit_q;   // Sampled parity bit
   logic                            stop1_low_q; // First stop seen low
   logic                            stop2_low_q; // Final stop seen low
   logic                            ones_odd;
   logic                            deciding_low;

   // Each data bit lands at its own index
   always_ff @(posedge clk) begin
      if (i_data_cap) begin
         data_q[i_bit_idx] <= i_rx;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         par_bit_q <= 1'b0;
      end else if (i_par_cap) begin
         par_bit_q <= i_rx;
      end else if (i_data_cap && i_bit_idx == '0) begin
         par_bit_q <= 1'b0;              // New frame, stays 0 without parity
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         stop1_low_q <= 1'b0;
         stop2_low_q <= 1'b0;
      end else begin
         if (!i_frame_mode) begin
            stop1_low_q <= 1'b0;         // No first stop in this mode
         end else if (i_stop1_cap) begin
            stop1_low_q <= ~i_rx;
         end
         if (i_stop2_cap) begin
            stop2_low_q <= ~i_rx;
         end
      end
   end

   assign ones_odd = ^{data_q, par_bit_q};       // Odd count of ones

   // Even mode wants an even count, odd mode an odd count
   assign o_parity_err = i_parity_mode[uart_rx_pkg::PAR_EN_BIT] &
                         (i_parity_mode[uart_rx_pkg::PAR_EVEN_BIT] ? ones_odd : ~ones_odd);

   assign o_frame_err = stop1_low_q | stop2_low_q;

   // Break decided by the first stop bit of the frame
   assign deciding_low = i_frame_mode ? stop1_low_q : stop2_low_q;
   assign o_break      = (data_q == '0) & ~par_bit_q & deciding_low;

   assign o_data = data_q;

endmodule

// File: uart_rx_out_buf.sv
////////////////////////////////////////////////////////////
// Output register for data and status
// No back-pressure, a new frame overwrites one not yet taken
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx_out_buf (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             i_load,        // BUFF strobe
   input  logic                             i_ready,       // Consumer takes it
   input  logic [uart_rx_pkg::DATA_W-1:0]   i_data,
   input  logic                             i_parity_err,
   input  logic                             i_frame_err,
   input  logic                             i_break,
   output logic [uart_rx_pkg::DATA_W-1:0]   o_data,
   output logic                             o_data_valid,
   output logic                             o_parity_err,
   output logic                             o_frame_err,
   output logic                             o_break
);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_data       <= '0;
         o_parity_err <= 1'b0;
         o_frame_err  <= 1'b0;
         o_break      <= 1'b0;
      end else if (i_load) begin
         o_data       <= i_data;
         o_parity_err <= i_parity_err;
         o_frame_err  <= i_frame_err;
         o_break      <= i_break;
      end
   end

   // Load beats the accept on the same clock
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_data_valid <= 1'b0;
      end else if (i_load) begin
         o_data_valid <= 1'b1;
      end else if (i_ready) begin
         o_data_valid <= 1'b0;
      end
   end

endmodule

// File: uart_rx.sv
////////////////////////////////////////////////////////////
// UART receiver top, 8 data bits, x8 oversampling
// Parity mode {even, enable}, frame mode 1 = two stop bits
// Always listening, output valid holds until i_ready is seen
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             i_baud_clk,
   input  logic [1:0]                       i_parity_mode,
   input  logic                             i_frame_mode,
   input  logic                             i_rx,
   input  logic                             i_ready,
   output logic [uart_rx_pkg::DATA_W-1:0]   o_data,
   output logic                             o_data_valid,
   output logic                             o_rx_ready,
   output logic                             o_break,
   output logic                             o_parity_err,
   output logic                             o_frame_err
);

   // Sampler to controller
   logic                              sync;
   logic                              mid_tick;
   logic                              last_tick;
   // Controller outputs
   logic                              hunt;
   logic                              frame_done;
   logic                              data_cap;
   logic [uart_rx_pkg::BIT_IDX_W-1:0] bit_idx;
   logic                              par_cap;
   logic                              stop1_cap;
   logic                              stop2_cap;
   logic                              buff;
   // Checker to output buffer
   logic [uart_rx_pkg::DATA_W-1:0]    chk_data;
   logic                              chk_parity_err;
   logic                              chk_frame_err;
   logic                              chk_break;

   uart_rx_sampler u_sampler (
      .clk          (clk),
      .rstn         (rstn),
      .i_baud_clk   (i_baud_clk),
      .i_rx         (i_rx),
      .i_hunt       (hunt),
      .i_frame_done (frame_done),
      .o_sync       (sync),
      .o_mid_tick   (mid_tick),
      .o_last_tick  (last_tick),
      .o_rx_ready   (o_rx_ready)
   );

   uart_rx_frame_ctrl u_ctrl (
      .clk           (clk),
      .rstn          (rstn),
      .i_sync        (sync),
      .i_mid_tick    (mid_tick),
      .i_last_tick   (last_tick),
      .i_parity_mode (i_parity_mode),
      .i_frame_mode  (i_frame_mode),
      .o_hunt        (hunt),
      .o_data_cap    (data_cap),
      .o_bit_idx     (bit_idx),
      .o_par_cap     (par_cap),
      .o_stop1_cap   (stop1_cap),
      .o_stop2_cap   (stop2_cap),
      .o_frame_done  (frame_done),
      .o_buff        (buff)
   );

   uart_rx_frame_check u_check (
      .clk           (clk),
      .rstn          (rstn),
      .i_rx          (i_rx),
      .i_data_cap    (data_cap),
      .i_bit_idx     (bit_idx),
      .i_par_cap     (par_cap),
      .i_stop1_cap   (stop1_cap),
      .i_stop2_cap   (stop2_cap),
      .i_parity_mode (i_parity_mode),
      .i_frame_mode  (i_frame_mode),
      .o_data        (chk_data),
      .o_parity_err  (chk_parity_err),
      .o_frame_err   (chk_frame_err),
      .o_break       (chk_break)
   );

   uart_rx_out_buf u_out_buf (
      .clk          (clk),
      .rstn         (rstn),
      .i_load       (buff),
      .i_ready      (i_ready),
      .i_data       (chk_data),
      .i_parity_err (chk_parity_err),
      .i_frame_err  (chk_frame_err),
      .i_break      (chk_break),
      .o_data       (o_data),
      .o_data_valid (o_data_valid),
      .o_parity_err (o_parity_err),
      .o_frame_err  (o_frame_err),
      .o_break      (o_break)
   );

endmodule

// File: tb_uart_rx_assert.sv
////////////////////////////////////////////////////////////
// Concurrent checks bound into uart_rx
// Watches the controller state through its internal name
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_uart_rx_assert (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     i_ready,
   input  logic                     i_data_valid,
   input  logic                     i_rx_ready,
   input  logic                     i_parity_err,
   input  logic                     i_frame_err,
   input  logic                     i_break,
   input  uart_rx_pkg::rx_state_t   i_state
);

   int fail_cnt = 0;                      // Read by the testbench at the end

   // Quiet outputs on the first clock out of reset
   property reset_quiet;
      @(posedge clk) $rose(rstn) |->
         (!i_data_valid && !i_parity_err && !i_frame_err && !i_break && i_rx_ready);
   endproperty

   // Valid only drops after the consumer took it
   property valid_held;
      @(posedge clk) disable iff (!rstn)
         $fell(i_data_valid) |-> $past(i_ready);
   endproperty

   property state_onehot;
      @(posedge clk) disable iff (!rstn) $onehot(i_state);
   endproperty

   a_reset_quiet: assert property (reset_quiet)
      else begin
         fail_cnt++;
         $error("Outputs not idle when reset was released");
      end

   a_valid_held: assert property (valid_held)
      else begin
         fail_cnt++;
         $error("o_data_valid fell without i_ready on the clock before");
      end

   a_state_onehot: assert property (state_onehot)
      else begin
         fail_cnt++;
         $error("Controller state is not one-hot");
      end

endmodule

bind uart_rx tb_uart_rx_assert u_assert (
   .clk          (clk),
   .rstn         (rstn),
   .i_ready      (i_ready),
   .i_data_valid (o_data_valid),
   .i_rx_ready   (o_rx_ready),
   .i_parity_err (o_parity_err),
   .i_frame_err  (o_frame_err),
   .i_break      (o_break),
   .i_state      (u_ctrl.state_q)
);

// File: tb_uart_rx.sv
////////////////////////////////////////////////////////////
// Testbench for uart_rx, tick every fourth clock, x8 bits
// Inputs change 1 ns after the rising edge
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_uart_rx;

   // About 40 frames of up to 12 bits, 8 ticks of 4 clocks each, plus margin
   localparam int TIMEOUT_CYC = 20000;

   logic        clk;
   logic        rstn;
   logic        i_baud_clk;
   logic [1:0]  i_parity_mode;                 // {even, enable}
   logic        i_frame_mode;                  // 1 = two stop bits
   logic        i_rx;
   logic        i_ready;
   logic [7:0]  o_data;
   logic        o_data_valid;
   logic        o_rx_ready;
   logic        o_break;
   logic        o_parity_err;
   logic        o_frame_err;

   logic [10:0] exp_q[$];                      // {break, frame, parity, data}
   logic [10:0] exp_word;
   logic        valid_q;
   logic [7:0]  held;
   logic [31:0] rnd;
   integer      seed;
   int          sb_errors;
   int          cycles;
   string       test_name;
   logic [1:0]  pmodes [3] = '{2'b00, 2'b01, 2'b11};   // None, odd, even

   uart_rx dut (
      .clk           (clk),
      .rstn          (rstn),
      .i_baud_clk    (i_baud_clk),
      .i_parity_mode (i_parity_mode),
      .i_frame_mode  (i_frame_mode),
      .i_rx          (i_rx),
      .i_ready       (i_ready),
      .o_data        (o_data),
      .o_data_valid  (o_data_valid),
      .o_rx_ready    (o_rx_ready),
      .o_break       (o_break),
      .o_parity_err  (o_parity_err),
      .o_frame_err   (o_frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Baud tick, one clock in four
   initial begin : tick_gen
      int div;
      div = 0;
      forever begin
         @(posedge clk);
         #1;
         div = (div + 1) % 4;
         i_baud_clk = (div == 0);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYC) begin
         $display("Timeout: run still going after %0d cycles", TIMEOUT_CYC);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic report_error(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      sb_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
   endtask

   // Scoreboard on each valid rise
   always @(posedge clk) begin
      if (o_data_valid && !valid_q) begin
         if (exp_q.size() == 0) begin
            sb_errors++;
            $display("Output frame appeared in %s with none expected", test_name);
         end else begin
            exp_word = exp_q.pop_front();
            assert ({o_break, o_frame_err, o_parity_err, o_data} == exp_word)
               else report_error("brk/ferr/perr/data", exp_word,
                                 {o_break, o_frame_err, o_parity_err, o_data});
         end
      end
      valid_q = o_data_valid;                  // Previous clock, for the rise
   end

   // Returns 1 ns after the n-th tick edge
   task automatic wait_ticks(input int n);
      repeat (n) begin
         @(posedge clk);
         while (!i_baud_clk) @(posedge clk);
      end
      #1;
   endtask

   // One frame, 8 ticks per bit, expected result queued first
   task automatic send_frame(input logic [7:0] data, input logic [1:0] pmode,
                             input logic two_stop, input logic bad_par,
                             input logic stop1_low, input logic stop2_low);
      logic par_bit;                           // Bit on the line
      logic rx_par;                            // Parity as the receiver keeps it
      logic perr;
      logic ferr;
      logic brk;
      logic deciding_low;
      par_bit = (pmode[1] ? ^data : ~^data) ^ bad_par;   // Even sends XOR of data
      rx_par  = pmode[0] ? par_bit : 1'b0;
      perr    = pmode[0] & bad_par;            // Only a flipped bit breaks parity
      ferr    = (two_stop & stop1_low) | stop2_low;
      deciding_low = two_stop ? stop1_low : stop2_low;
      brk     = (data == 8'h00) & ~rx_par & deciding_low;
      exp_q.push_back({brk, ferr, perr, data});
      i_parity_mode = pmode;
      i_frame_mode  = two_stop;
      i_rx = 1'b0;                             // Start
      wait_ticks(8);
      for (int i = 0; i < 8; i++) begin
         i_rx = data[i];                       // LSB first
         wait_ticks(8);
      end
      if (pmode[0]) begin
         i_rx = par_bit;
         wait_ticks(8);
      end
      if (two_stop) begin
         i_rx = ~stop1_low;
         wait_ticks(8);
      end
      i_rx = ~stop2_low;
      wait_ticks(8);
      i_rx = 1'b1;                             // Idle gap re-arms the edge detector
      wait_ticks(4);
   endtask

   // Short low pulse, rejected at the start bit middle
   task automatic send_glitch(input int len);
      i_rx = 1'b0;
      wait_ticks(len);
      i_rx = 1'b1;
      wait_ticks(6);
      assert (o_rx_ready) else report_error("o_rx_ready after glitch", 1, o_rx_ready);
   endtask

   initial begin
      seed          = 32'hb518_caf0;
      rstn          = 1'b0;
      i_baud_clk    = 1'b0;
      i_parity_mode = 2'b00;
      i_frame_mode  = 1'b0;
      i_rx          = 1'b1;
      i_ready       = 1'b1;
      valid_q       = 1'b0;
      sb_errors     = 0;
      cycles        = 0;
      test_name     = "reset";
      repeat (3) @(posedge clk);
      #1 rstn = 1'b1;
      wait_ticks(4);                           // Line seen high before first start

      test_name = "all_modes";
      for (int p = 0; p < 3; p++) begin
         for (int f = 0; f < 2; f++) begin
            repeat (4) begin
               rnd = $random(seed);
               send_frame(rnd[7:0], pmodes[p], f[0], 1'b0, 1'b0, 1'b0);
            end
         end
      end

      test_name = "parity_err";
      rnd = $random(seed);
      send_frame(rnd[7:0], 2'b01, 1'b0, 1'b1, 1'b0, 1'b0);
      send_frame(rnd[15:8], 2'b11, 1'b0, 1'b1, 1'b0, 1'b0);
      send_frame(rnd[23:16], 2'b01, 1'b1, 1'b1, 1'b0, 1'b0);
      send_frame(rnd[31:24], 2'b11, 1'b1, 1'b1, 1'b0, 1'b0);
      send_frame(rnd[7:0], 2'b00, 1'b0, 1'b1, 1'b0, 1'b0);   // No parity bit sent

      test_name = "frame_err";
      rnd = $random(seed);
      send_frame(rnd[7:0], 2'b00, 1'b0, 1'b0, 1'b0, 1'b1);
      send_frame(rnd[15:8], 2'b11, 1'b1, 1'b0, 1'b0, 1'b1);
      send_frame(rnd[23:16], 2'b01, 1'b1, 1'b0, 1'b1, 1'b0);

      test_name = "break";
      send_frame(8'h00, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1);
      send_frame(8'h00, 2'b11, 1'b1, 1'b0, 1'b1, 1'b0);
      send_frame(8'h00, 2'b01, 1'b0, 1'b1, 1'b0, 1'b1);      // Odd, parity forced 0
      send_frame(8'h00, 2'b00, 1'b1, 1'b0, 1'b0, 1'b1);      // Final stop only, no break

      test_name = "ready_hold";
      for (int k = 0; k < 2; k++) begin
         i_ready = 1'b0;
         rnd = $random(seed);
         send_frame(rnd[7:0], k ? 2'b00 : 2'b11, k[0], 1'b0, 1'b0, 1'b0);
         held = o_data;
         repeat (12) begin
            @(posedge clk);
            #1;
            assert (o_data_valid) else report_error("valid while held", 1, o_data_valid);
            assert (o_data == held) else report_error("data while held", held, o_data);
         end
         i_ready = 1'b1;
         @(posedge clk);
         #1;
         assert (!o_data_valid) else report_error("valid after accept", 0, o_data_valid);
      end

      test_name = "glitch";
      for (int g = 1; g < 3; g++) begin
         send_glitch(g);
         rnd = $random(seed);
         send_frame(rnd[7:0], 2'b01, 1'b0, 1'b0, 1'b0, 1'b0);
      end

      repeat (20) @(posedge clk);
      if (exp_q.size() != 0) begin
         sb_errors++;
         $display("%0d expected frames were never received", exp_q.size());
      end
      $display("Checks done: %0d scoreboard errors, %0d assertion failures",
               sb_errors, dut.u_assert.fail_cnt);
      if (sb_errors == 0 && dut.u_assert.fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: verilog.f
uart_rx_pkg.sv
uart_rx_sampler.sv
uart_rx_frame_ctrl.sv
uart_rx_frame_check.sv
uart_rx_out_buf.sv
uart_rx.sv
tb_uart_rx_assert.sv
tb_uart_rx.sv
